// File: hdl/pad_pkg.sv
`default_nettype none

package pad_pkg;

    // clk cycles per pad tick.
    localparam int TICK_DIV = 4;
    // ticks per poll frame.
    localparam int FRAME_TICKS = 64;
    localparam int LATCH_TICKS = 2;
    localparam int DATA_START_TICK = 3;
    localparam int PAD_BITS = 16;
    localparam int BTN_COUNT = 12;
    // first slot after the last pad clock high slot.
    localparam int DATA_END_TICK = DATA_START_TICK + 2 * PAD_BITS;

    typedef logic [6:0] tick_t;

    // 1 = pressed, bit 0 is the first bit shifted out of the pad.
    typedef logic [BTN_COUNT-1:0] buttons_t;

    typedef logic [PAD_BITS-1:0] pad_shift_t;

    // sample and frame_done are one cycle strobes.
    typedef struct packed {
        logic latch;
        logic pad_clk;
        logic sample;
        logic frame_done;
    } pad_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/axil_pkg.sv
`default_nettype none

package axil_pkg;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // register map.
    localparam axil_addr_t ADDR_BUTTONS = 4'h0;
    localparam axil_addr_t ADDR_FRAMES  = 4'h4;

    typedef logic [15:0] frame_count_t;

    typedef struct packed {
        axil_addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

endpackage

`default_nettype wire

// File: hdl/pad_poll_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pad_poll_sequencer
    import pad_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      aresetn,
    output pad_ctrl_t      ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        LATCH,
        BITS
    } phase_t;

    logic [$clog2(TICK_DIV)-1:0] div_cnt;
    logic   tick;
    tick_t  slot;
    tick_t  bit_offset;
    logic   clk_high;
    phase_t slot_phase;
    phase_t phase;
    logic   latch_q;
    logic   pad_clk_q;
    logic   frame_done_q;
    logic   sample;

    // one tick strobe every TICK_DIV clk cycles.
    assign tick = (div_cnt == TICK_DIV - 1);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // slot holds the slot whose outputs are set on the next tick.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            slot <= '0;
        end else if (tick) begin
            if (slot == tick_t'(FRAME_TICKS - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    always_comb begin
        if (slot < tick_t'(LATCH_TICKS)) begin
            slot_phase = LATCH;
        end else if (slot >= tick_t'(DATA_START_TICK) && slot < tick_t'(DATA_END_TICK)) begin
            slot_phase = BITS;
        end else begin
            slot_phase = IDLE;
        end
    end

    // second slot of each bit period is the high half.
    assign bit_offset = slot - tick_t'(DATA_START_TICK);
    assign clk_high = bit_offset[0];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            phase     <= IDLE;
            latch_q   <= 1'b0;
            pad_clk_q <= 1'b0;
        end else if (tick) begin
            phase     <= slot_phase;
            latch_q   <= (slot_phase == LATCH);
            pad_clk_q <= (slot_phase == BITS) && clk_high;
        end
    end

    // leaving the bit slots ends the frame.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= tick && (phase == BITS) && (slot_phase != BITS);
        end
    end

    // high in the cycle whose closing edge raises pad_clk, data still shows bit k.
    assign sample = tick && (slot_phase == BITS) && clk_high;

    assign ctrl = '{
        latch:      latch_q,
        pad_clk:    pad_clk_q,
        sample:     sample,
        frame_done: frame_done_q
    };

endmodule

`default_nettype wire

// File: hdl/pad_shift_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module pad_shift_receiver
    import pad_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      aresetn,
    input  wire pad_ctrl_t ctrl,
    input  wire logic      data,
    output buttons_t       buttons
);

    pad_shift_t shift_reg;

    // pad data is active low.
    // new bits enter at the top so the first bit ends in bit 0.
    always_ff @(posedge clk) begin
        if (ctrl.latch) begin
            shift_reg <= '0;
        end else if (ctrl.sample) begin
            shift_reg <= {~data, shift_reg[PAD_BITS-1:1]};
        end
    end

    // the trailing four bits are dropped.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            buttons <= '0;
        end else if (ctrl.frame_done) begin
            buttons <= shift_reg[BTN_COUNT-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/pad_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module pad_axil_regs
    import pad_pkg::*;
    import axil_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     aresetn,

    input  wire logic     arvalid,
    output logic          arready,
    input  wire axil_ar_t ar,

    output logic          rvalid,
    input  wire logic     rready,
    output axil_r_t       r,

    input  wire logic     frame_done,
    input  wire buttons_t pad0_buttons,
    input  wire buttons_t pad1_buttons
);

    frame_count_t frame_count;
    axil_r_t      next_r;
    logic         ar_fire;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            frame_count <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // one read in flight at a time.
    assign arready = !rvalid;
    assign ar_fire = arvalid && arready;

    always_comb begin
        case (ar.addr)
            ADDR_BUTTONS: begin
                next_r.data = axil_data_t'({pad1_buttons, pad0_buttons});
                next_r.resp = RESP_OKAY;
            end
            ADDR_FRAMES: begin
                next_r.data = axil_data_t'(frame_count);
                next_r.resp = RESP_OKAY;
            end
            default: begin
                next_r.data = '0;
                next_r.resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // response stays put until the master takes it.
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r <= next_r;
        end
    end

endmodule

`default_nettype wire

// File: hdl/snes_pad_reader.sv
`timescale 1ns/100ps
`default_nettype none

module snes_pad_reader
    import pad_pkg::*;
    import axil_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     aresetn,

    input  wire logic     arvalid,
    output logic          arready,
    input  wire axil_ar_t ar,

    output logic          rvalid,
    input  wire logic     rready,
    output axil_r_t       r,

    input  wire logic     pad0_data,
    input  wire logic     pad1_data,
    output logic          pad_latch,
    output logic          pad_clk
);

    pad_ctrl_t ctrl;
    buttons_t  pad0_buttons;
    buttons_t  pad1_buttons;

    pad_poll_sequencer u_sequencer (
        .clk     (clk),
        .aresetn (aresetn),
        .ctrl    (ctrl)
    );

    // both pads share latch and clock.
    assign pad_latch = ctrl.latch;
    assign pad_clk   = ctrl.pad_clk;

    pad_shift_receiver u_pad0 (
        .clk     (clk),
        .aresetn (aresetn),
        .ctrl    (ctrl),
        .data    (pad0_data),
        .buttons (pad0_buttons)
    );

    pad_shift_receiver u_pad1 (
        .clk     (clk),
        .aresetn (aresetn),
        .ctrl    (ctrl),
        .data    (pad1_data),
        .buttons (pad1_buttons)
    );

    pad_axil_regs u_regs (
        .clk          (clk),
        .aresetn      (aresetn),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r),
        .frame_done   (ctrl.frame_done),
        .pad0_buttons (pad0_buttons),
        .pad1_buttons (pad1_buttons)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic aresetn
);

    localparam int PERIOD = 100;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release lines up with the stimulus delay.
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 aresetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/snes_pad_model.sv
`timescale 1ns/100ps
`default_nettype none

module snes_pad_model
    import pad_pkg::*;
(
    input  wire logic     latch,
    input  wire logic     pad_clk,
    input  wire buttons_t buttons,
    output logic          data
);

    // 1 = pressed, bit 0 goes out first.
    logic [PAD_BITS-1:0] pressed;

    initial begin
        pressed = '0;
    end

    // parallel load on latch, shift on each pad clock rise.
    always @(posedge latch or posedge pad_clk) begin
        if (latch) begin
            pressed <= {{(PAD_BITS - BTN_COUNT){1'b0}}, buttons};
        end else begin
            pressed <= {1'b1, pressed[PAD_BITS-1:1]};
        end
    end

    // line is active low.
    assign data = ~pressed[0];

endmodule

`default_nettype wire

// File: test/snes_pad_reader_tb.sv
`timescale 1ns/100ps
`default_nettype none

module snes_pad_reader_tb
    import pad_pkg::*;
    import axil_pkg::*;
;

    localparam int DRIVE_DELAY = 10;
    localparam int FRAME_CLKS = 256;
    localparam int SETTLE_FRAMES = 2;
    localparam int RANDOM_ROUNDS = 10;
    localparam int COUNT_FRAMES = 3;
    localparam int PIN_FRAMES = 1;
    localparam int STALL_CYCLES = 20;
    localparam int READ_TIMEOUT = 16;
    localparam int FRAMES_WAITED = SETTLE_FRAMES * (1 + RANDOM_ROUNDS) + COUNT_FRAMES
                                   + PIN_FRAMES;
    localparam int WATCHDOG_CYCLES = FRAMES_WAITED * FRAME_CLKS + 2000;

    // b is the first bit on the wire.
    localparam buttons_t BTN_B_ONLY = 12'h001;
    localparam buttons_t BTN_ALL = 12'hfff;

    logic     clk;
    logic     aresetn;
    logic     arvalid;
    logic     arready;
    axil_ar_t ar;
    logic     rvalid;
    logic     rready;
    axil_r_t  r;
    logic     pad0_data;
    logic     pad1_data;
    logic     pad_latch;
    logic     pad_clk;
    buttons_t pad0_buttons;
    buttons_t pad1_buttons;
    integer   seed;
    int       errors;
    int       checks;

    tb_clock_gen clock_gen (
        .clk     (clk),
        .aresetn (aresetn)
    );

    snes_pad_reader UUT (
        .clk       (clk),
        .aresetn   (aresetn),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r),
        .pad0_data (pad0_data),
        .pad1_data (pad1_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk)
    );

    snes_pad_model pad0_model (
        .latch   (pad_latch),
        .pad_clk (pad_clk),
        .buttons (pad0_buttons),
        .data    (pad0_data)
    );

    snes_pad_model pad1_model (
        .latch   (pad_latch),
        .pad_clk (pad_clk),
        .buttons (pad1_buttons),
        .data    (pad1_data)
    );

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_frames(input int frames);
        repeat (frames * FRAME_CLKS) next_cycle();
    endtask

    task automatic check_data(input string name, input axil_data_t expected,
                              input axil_data_t observed);
        checks++;
        if (observed !== expected) begin
            errors++;
            $display("Fail %s expected 0x%h observed 0x%h", name, expected, observed);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t expected,
                              input axil_resp_t observed);
        checks++;
        if (observed !== expected) begin
            errors++;
            $display("Fail %s expected 0x%h observed 0x%h", name, expected, observed);
        end
    endtask

    task automatic check_buttons(input string name, input buttons_t expected,
                                 input buttons_t observed);
        checks++;
        if (observed !== expected) begin
            errors++;
            $display("Fail %s expected 0x%h observed 0x%h", name, expected, observed);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic observed);
        checks++;
        if (observed !== expected) begin
            errors++;
            $display("Fail %s expected 0x%h observed 0x%h", name, expected, observed);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int observed);
        checks++;
        if (observed != expected) begin
            errors++;
            $display("Fail %s expected 0x%h observed 0x%h", name, expected, observed);
        end
    endtask

    task automatic check_frame_delta(input frame_count_t low, input frame_count_t high,
                                     input frame_count_t observed);
        checks++;
        if (observed < low || observed > high) begin
            errors++;
            $display("Fail frame_count delta expected 0x%h..0x%h observed 0x%h",
                     low, high, observed);
        end
    endtask

    // pad1 in 23:12, pad0 in 11:0.
    function automatic axil_data_t button_word(input buttons_t p0, input buttons_t p1);
        axil_data_t word;
        word = '0;
        word[BTN_COUNT-1:0] = p0;
        word[2*BTN_COUNT-1:BTN_COUNT] = p1;
        return word;
    endfunction

    task automatic send_address(input axil_addr_t addr);
        logic accepted;
        int   waited;
        accepted = 1'b0;
        waited = 0;
        arvalid = 1'b1;
        ar.addr = addr;
        while (!accepted && waited < READ_TIMEOUT) begin
            accepted = arready;
            next_cycle();
            waited++;
        end
        arvalid = 1'b0;
        if (!accepted) begin
            errors++;
            $display("read address 0x%h was never accepted", addr);
        end
    endtask

    task automatic wait_response(output axil_r_t resp);
        int waited;
        waited = 0;
        while (!rvalid && waited < READ_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!rvalid) begin
            errors++;
            $display("no read response arrived within %0d cycles", READ_TIMEOUT);
        end
        resp = r;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_r_t resp);
        rready = 1'b1;
        send_address(addr);
        wait_response(resp);
        // transfer completes on this edge.
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic read_and_compare_buttons(input buttons_t p0, input buttons_t p1);
        axil_r_t resp;
        axil_read(ADDR_BUTTONS, resp);
        check_resp("r.resp", RESP_OKAY, resp.resp);
        check_buttons("pad0 buttons", p0, resp.data[BTN_COUNT-1:0]);
        check_buttons("pad1 buttons", p1, resp.data[2*BTN_COUNT-1:BTN_COUNT]);
        check_data("r.data", button_word(p0, p1), resp.data);
    endtask

    // hold registers are still clear.
    task automatic read_after_reset();
        axil_r_t resp;
        check_flag("rvalid", 1'b0, rvalid);
        check_flag("arready", 1'b1, arready);
        axil_read(ADDR_BUTTONS, resp);
        check_data("r.data", '0, resp.data);
        check_resp("r.resp", RESP_OKAY, resp.resp);
    endtask

    task automatic fixed_patterns();
        pad0_buttons = BTN_B_ONLY;
        pad1_buttons = BTN_ALL;
        wait_frames(SETTLE_FRAMES);
        read_and_compare_buttons(BTN_B_ONLY, BTN_ALL);
    endtask

    task automatic random_patterns();
        repeat (RANDOM_ROUNDS) begin
            pad0_buttons = buttons_t'($random(seed));
            pad1_buttons = buttons_t'($random(seed));
            wait_frames(SETTLE_FRAMES);
            read_and_compare_buttons(pad0_buttons, pad1_buttons);
        end
    endtask

    task automatic frame_counter_rate();
        axil_r_t      first;
        axil_r_t      second;
        frame_count_t delta;
        axil_read(ADDR_FRAMES, first);
        check_resp("r.resp", RESP_OKAY, first.resp);
        wait_frames(COUNT_FRAMES);
        axil_read(ADDR_FRAMES, second);
        check_resp("r.resp", RESP_OKAY, second.resp);
        delta = second.data[15:0] - first.data[15:0];
        // read skew can move one frame_done in or out of the window.
        check_frame_delta(frame_count_t'(COUNT_FRAMES - 1), frame_count_t'(COUNT_FRAMES + 1),
                          delta);
    endtask

    task automatic bad_address_read();
        axil_r_t resp;
        axil_read(4'h8, resp);
        check_data("r.data", '0, resp.data);
        check_resp("r.resp", RESP_SLVERR, resp.resp);
    endtask

    // one full frame of the shared pad lines.
    task automatic pad_pin_timing();
        int   latch_cycles;
        int   clk_rises;
        int   clk_high_cycles;
        logic prev_clk;
        latch_cycles = 0;
        clk_rises = 0;
        clk_high_cycles = 0;
        prev_clk = pad_clk;
        repeat (PIN_FRAMES * FRAME_CLKS) begin
            next_cycle();
            if (pad_latch) begin
                latch_cycles++;
            end
            if (pad_clk) begin
                clk_high_cycles++;
            end
            if (pad_clk && !prev_clk) begin
                clk_rises++;
            end
            prev_clk = pad_clk;
        end
        check_count("pad_latch high cycles", PIN_FRAMES * LATCH_TICKS * TICK_DIV,
                    latch_cycles);
        check_count("pad_clk rising edges", PIN_FRAMES * PAD_BITS, clk_rises);
        check_count("pad_clk high cycles", PIN_FRAMES * PAD_BITS * TICK_DIV,
                    clk_high_cycles);
    endtask

    task automatic read_back_pressure();
        axil_r_t held;
        rready = 1'b0;
        send_address(ADDR_FRAMES);
        wait_response(held);
        check_resp("r.resp", RESP_OKAY, held.resp);
        // a second request waits while the first is unanswered.
        arvalid = 1'b1;
        ar.addr = 4'h8;
        repeat (STALL_CYCLES) begin
            next_cycle();
            check_flag("rvalid", 1'b1, rvalid);
            check_flag("arready", 1'b0, arready);
            check_data("r.data", held.data, r.data);
            check_resp("r.resp", held.resp, r.resp);
        end
        rready = 1'b1;
        next_cycle();
        arvalid = 1'b0;
        check_flag("rvalid", 1'b0, rvalid);
        check_flag("arready", 1'b1, arready);
        rready = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clock cycles, tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed = 32'h8ce1_b433;
        errors = 0;
        checks = 0;
        arvalid = 1'b0;
        ar = '0;
        rready = 1'b0;
        // nonzero so an early read shows the hold registers, not the pads.
        pad0_buttons = 12'ha5a;
        pad1_buttons = 12'h5a5;
        @(posedge aresetn);
        read_after_reset();
        fixed_patterns();
        random_patterns();
        frame_counter_rate();
        bad_address_read();
        pad_pin_timing();
        read_back_pressure();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/pad_pkg.sv
hdl/axil_pkg.sv
hdl/pad_poll_sequencer.sv
hdl/pad_shift_receiver.sv
hdl/pad_axil_regs.sv
hdl/snes_pad_reader.sv
test/tb_clock_gen.sv
test/snes_pad_model.sv
test/snes_pad_reader_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = snes_pad_reader_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
